/* pcinc8_pkg.sv */
// shared definitions for the 65816 instruction walker
// opcode map, status flag positions, widths and the fetch window view

package pcinc8_pkg;

	// ============================================================
	// widths and control encodings
	// ============================================================

	// width of the instruction length returned by the decoder
	localparam int INC_W = 4;

	// suppress value that lets the walker run
	localparam logic [3:0] SUPPRESS_NONE = 4'hF;

	// bit positions inside the processor status byte
	localparam int FLAG_C = 0;
	localparam int FLAG_X = 4;
	localparam int FLAG_M = 5;

	// ============================================================
	// 65816 opcode map, grouped by addressing mode
	// ============================================================

	// immediate, accumulator sized and index sized
	localparam logic [7:0]
		ORA_IMM = 8'h09, AND_IMM = 8'h29, EOR_IMM = 8'h49, ADC_IMM = 8'h69,
		BIT_IMM = 8'h89, LDA_IMM = 8'hA9, CMP_IMM = 8'hC9, SBC_IMM = 8'hE9,
		LDY_IMM = 8'hA0, LDX_IMM = 8'hA2, CPY_IMM = 8'hC0, CPX_IMM = 8'hE0;

	// direct page
	localparam logic [7:0]
		ORA_ZP = 8'h05, AND_ZP = 8'h25, EOR_ZP = 8'h45, ADC_ZP = 8'h65,
		STA_ZP = 8'h85, LDA_ZP = 8'hA5, CMP_ZP = 8'hC5, SBC_ZP = 8'hE5,
		TSB_ZP = 8'h04, TRB_ZP = 8'h14, BIT_ZP = 8'h24, STZ_ZP = 8'h64,
		STY_ZP = 8'h84, STX_ZP = 8'h86, LDY_ZP = 8'hA4, LDX_ZP = 8'hA6,
		CPY_ZP = 8'hC4, CPX_ZP = 8'hE4, ASL_ZP = 8'h06, ROL_ZP = 8'h26,
		LSR_ZP = 8'h46, ROR_ZP = 8'h66, DEC_ZP = 8'hC6, INC_ZP = 8'hE6;

	// direct page indexed by x, plus the two y indexed forms
	localparam logic [7:0]
		ORA_ZPX = 8'h15, AND_ZPX = 8'h35, EOR_ZPX = 8'h55, ADC_ZPX = 8'h75,
		STA_ZPX = 8'h95, LDA_ZPX = 8'hB5, CMP_ZPX = 8'hD5, SBC_ZPX = 8'hF5,
		BIT_ZPX = 8'h34, STZ_ZPX = 8'h74, STY_ZPX = 8'h94, LDY_ZPX = 8'hB4,
		ASL_ZPX = 8'h16, ROL_ZPX = 8'h36, LSR_ZPX = 8'h56, ROR_ZPX = 8'h76,
		DEC_ZPX = 8'hD6, INC_ZPX = 8'hF6, STX_ZPY = 8'h96, LDX_ZPY = 8'hB6;

	// direct page indirect forms and stack relative
	localparam logic [7:0]
		ORA_IX = 8'h01, AND_IX = 8'h21, EOR_IX = 8'h41, ADC_IX = 8'h61,
		STA_IX = 8'h81, LDA_IX = 8'hA1, CMP_IX = 8'hC1, SBC_IX = 8'hE1,
		ORA_IY = 8'h11, AND_IY = 8'h31, EOR_IY = 8'h51, ADC_IY = 8'h71,
		STA_IY = 8'h91, LDA_IY = 8'hB1, CMP_IY = 8'hD1, SBC_IY = 8'hF1,
		ORA_I = 8'h12, AND_I = 8'h32, EOR_I = 8'h52, ADC_I = 8'h72,
		STA_I = 8'h92, LDA_I = 8'hB2, CMP_I = 8'hD2, SBC_I = 8'hF2,
		ORA_IL = 8'h07, AND_IL = 8'h27, EOR_IL = 8'h47, ADC_IL = 8'h67,
		STA_IL = 8'h87, LDA_IL = 8'hA7, CMP_IL = 8'hC7, SBC_IL = 8'hE7,
		ORA_IYL = 8'h17, AND_IYL = 8'h37, EOR_IYL = 8'h57, ADC_IYL = 8'h77,
		STA_IYL = 8'h97, LDA_IYL = 8'hB7, CMP_IYL = 8'hD7, SBC_IYL = 8'hF7,
		ORA_DSP = 8'h03, AND_DSP = 8'h23, EOR_DSP = 8'h43, ADC_DSP = 8'h63,
		STA_DSP = 8'h83, LDA_DSP = 8'hA3, CMP_DSP = 8'hC3, SBC_DSP = 8'hE3,
		ORA_DSPIY = 8'h13, AND_DSPIY = 8'h33, EOR_DSPIY = 8'h53, ADC_DSPIY = 8'h73,
		STA_DSPIY = 8'h93, LDA_DSPIY = 8'hB3, CMP_DSPIY = 8'hD3, SBC_DSPIY = 8'hF3;

	// absolute, absolute indexed and long
	localparam logic [7:0]
		ORA_ABS = 8'h0D, AND_ABS = 8'h2D, EOR_ABS = 8'h4D, ADC_ABS = 8'h6D,
		STA_ABS = 8'h8D, LDA_ABS = 8'hAD, CMP_ABS = 8'hCD, SBC_ABS = 8'hED,
		TSB_ABS = 8'h0C, TRB_ABS = 8'h1C, BIT_ABS = 8'h2C, STY_ABS = 8'h8C,
		STZ_ABS = 8'h9C, STX_ABS = 8'h8E, LDY_ABS = 8'hAC, LDX_ABS = 8'hAE,
		CPY_ABS = 8'hCC, CPX_ABS = 8'hEC, ASL_ABS = 8'h0E, ROL_ABS = 8'h2E,
		LSR_ABS = 8'h4E, ROR_ABS = 8'h6E, DEC_ABS = 8'hCE, INC_ABS = 8'hEE,
		ORA_ABSX = 8'h1D, AND_ABSX = 8'h3D, EOR_ABSX = 8'h5D, ADC_ABSX = 8'h7D,
		STA_ABSX = 8'h9D, LDA_ABSX = 8'hBD, CMP_ABSX = 8'hDD, SBC_ABSX = 8'hFD,
		BIT_ABSX = 8'h3C, STZ_ABSX = 8'h9E, LDY_ABSX = 8'hBC, ASL_ABSX = 8'h1E,
		ROL_ABSX = 8'h3E, LSR_ABSX = 8'h5E, ROR_ABSX = 8'h7E, DEC_ABSX = 8'hDE,
		INC_ABSX = 8'hFE, LDX_ABSY = 8'hBE,
		ORA_ABSY = 8'h19, AND_ABSY = 8'h39, EOR_ABSY = 8'h59, ADC_ABSY = 8'h79,
		STA_ABSY = 8'h99, LDA_ABSY = 8'hB9, CMP_ABSY = 8'hD9, SBC_ABSY = 8'hF9,
		ORA_AL = 8'h0F, AND_AL = 8'h2F, EOR_AL = 8'h4F, ADC_AL = 8'h6F,
		STA_AL = 8'h8F, LDA_AL = 8'hAF, CMP_AL = 8'hCF, SBC_AL = 8'hEF,
		ORA_ALX = 8'h1F, AND_ALX = 8'h3F, EOR_ALX = 8'h5F, ADC_ALX = 8'h7F,
		STA_ALX = 8'h9F, LDA_ALX = 8'hBF, CMP_ALX = 8'hDF, SBC_ALX = 8'hFF;

	// implied, accumulator and stack forms
	localparam logic [7:0]
		ASL_ACC = 8'h0A, ROL_ACC = 8'h2A, LSR_ACC = 8'h4A, ROR_ACC = 8'h6A,
		INA = 8'h1A, DEA = 8'h3A, INY = 8'hC8, DEY = 8'h88, INX = 8'hE8, DEX = 8'hCA,
		CLC = 8'h18, SEC = 8'h38, CLI = 8'h58, SEI = 8'h78, CLV = 8'hB8,
		CLD = 8'hD8, SED = 8'hF8, XCE = 8'hFB, WDM = 8'h42, STP = 8'hDB,
		WAI = 8'hCB, NOP = 8'hEA, XBA = 8'hEB, TCS = 8'h1B, TSC = 8'h3B,
		TAY = 8'hA8, TYA = 8'h98, TAX = 8'hAA, TXA = 8'h8A, TSX = 8'hBA,
		TXS = 8'h9A, TYX = 8'hBB, TXY = 8'h9B, TCD = 8'h5B, TDC = 8'h7B,
		PHP = 8'h08, PHA = 8'h48, PHX = 8'hDA, PHY = 8'h5A, PHK = 8'h4B,
		PHB = 8'h8B, PHD = 8'h0B, PLP = 8'h28, PLA = 8'h68, PLX = 8'hFA,
		PLY = 8'h7A, PLB = 8'hAB, PLD = 8'h2B, PEA = 8'hF4, PER = 8'h62,
		PEI = 8'hD4, MVN = 8'h54, MVP = 8'h44;

	// flow control, mode changes and interrupts
	localparam logic [7:0]
		BRK = 8'h00, COP = 8'h02, SEP = 8'hE2, REP = 8'hC2,
		BPL = 8'h10, BMI = 8'h30, BVC = 8'h50, BVS = 8'h70, BRA = 8'h80,
		BCC = 8'h90, BCS = 8'hB0, BNE = 8'hD0, BEQ = 8'hF0, BRL = 8'h82,
		JMP = 8'h4C, JML = 8'h5C, JMP_IND = 8'h6C, JMP_INDX = 8'h7C,
		JML_IND = 8'hDC, JSR = 8'h20, JSR_INDX = 8'hFC, JSL = 8'h22,
		RTS = 8'h60, RTL = 8'h6B, RTI = 8'h40;

	// ============================================================
	// fetch window, four bytes starting at pc
	// ============================================================

	// opcode sits in the low byte, operand bytes follow in address order
	typedef struct packed {
		logic [23:0] operand;
		logic [7:0]  opcode;
	} fetch_inst_t;

	// bytes[0] is the byte at pc
	typedef union packed {
		logic [3:0][7:0] bytes;
		fetch_inst_t     inst;
	} fetch_win_t;

endpackage

/* pcinc8.sv */
// 65816 instruction length decoder
// returns the byte count of an opcode for the current m and x widths,
// zero for flow changes and unimplemented codes, and zero on suppress

`timescale 1ns/1ps

module pcinc8 (
	input  logic [7:0]                   opcode,
	input  logic [3:0]                   suppress_pcinc,
	input  logic                         m16,
	input  logic                         xb16,
	output logic [pcinc8_pkg::INC_W-1:0] inc,
	output logic                         hold
);

	// any suppress value other than all ones stalls the walker
	assign hold = (suppress_pcinc != pcinc8_pkg::SUPPRESS_NONE);

	always_comb begin
		inc = '0;
		if (!hold) begin
			case (opcode)
			// ====================================================
			// single byte forms
			// ====================================================
			pcinc8_pkg::CLC, pcinc8_pkg::SEC, pcinc8_pkg::CLD, pcinc8_pkg::SED,
			pcinc8_pkg::CLV, pcinc8_pkg::CLI, pcinc8_pkg::SEI,
			pcinc8_pkg::TCS, pcinc8_pkg::TSC, pcinc8_pkg::TAY, pcinc8_pkg::TYA,
			pcinc8_pkg::TAX, pcinc8_pkg::TXA, pcinc8_pkg::TSX, pcinc8_pkg::TXS,
			pcinc8_pkg::TYX, pcinc8_pkg::TXY, pcinc8_pkg::TCD, pcinc8_pkg::TDC,
			pcinc8_pkg::XBA, pcinc8_pkg::INY, pcinc8_pkg::DEY, pcinc8_pkg::INX,
			pcinc8_pkg::DEX, pcinc8_pkg::INA, pcinc8_pkg::DEA, pcinc8_pkg::NOP,
			// wdm is walked as one byte, the same as the 65002 path
			pcinc8_pkg::XCE, pcinc8_pkg::WDM, pcinc8_pkg::STP, pcinc8_pkg::WAI,
			pcinc8_pkg::ASL_ACC, pcinc8_pkg::LSR_ACC, pcinc8_pkg::ROR_ACC,
			pcinc8_pkg::ROL_ACC,
			pcinc8_pkg::PHP, pcinc8_pkg::PHA, pcinc8_pkg::PHX, pcinc8_pkg::PHY,
			pcinc8_pkg::PHK, pcinc8_pkg::PHB, pcinc8_pkg::PHD, pcinc8_pkg::PLP,
			pcinc8_pkg::PLA, pcinc8_pkg::PLX, pcinc8_pkg::PLY, pcinc8_pkg::PLB,
			pcinc8_pkg::PLD:
				inc = 4'd1;

			// the immediate width follows the accumulator or index size
			pcinc8_pkg::ADC_IMM, pcinc8_pkg::SBC_IMM, pcinc8_pkg::CMP_IMM,
			pcinc8_pkg::AND_IMM, pcinc8_pkg::ORA_IMM, pcinc8_pkg::EOR_IMM,
			pcinc8_pkg::LDA_IMM, pcinc8_pkg::BIT_IMM:
				inc = m16 ? 4'd3 : 4'd2;
			pcinc8_pkg::LDX_IMM, pcinc8_pkg::LDY_IMM, pcinc8_pkg::CPX_IMM,
			pcinc8_pkg::CPY_IMM:
				inc = xb16 ? 4'd3 : 4'd2;

			// ====================================================
			// one operand byte
			// ====================================================
			// branches fall through, the walker does not follow a target
			pcinc8_pkg::SEP, pcinc8_pkg::REP, pcinc8_pkg::PEI,
			pcinc8_pkg::BPL, pcinc8_pkg::BMI, pcinc8_pkg::BCS, pcinc8_pkg::BCC,
			pcinc8_pkg::BVS, pcinc8_pkg::BVC, pcinc8_pkg::BEQ, pcinc8_pkg::BNE,
			pcinc8_pkg::BRA,
			pcinc8_pkg::TRB_ZP, pcinc8_pkg::TSB_ZP, pcinc8_pkg::ADC_ZP,
			pcinc8_pkg::SBC_ZP, pcinc8_pkg::CMP_ZP, pcinc8_pkg::AND_ZP,
			pcinc8_pkg::ORA_ZP, pcinc8_pkg::EOR_ZP, pcinc8_pkg::LDA_ZP,
			pcinc8_pkg::STA_ZP, pcinc8_pkg::LDY_ZP, pcinc8_pkg::LDX_ZP,
			pcinc8_pkg::STY_ZP, pcinc8_pkg::STX_ZP, pcinc8_pkg::CPX_ZP,
			pcinc8_pkg::CPY_ZP, pcinc8_pkg::BIT_ZP, pcinc8_pkg::STZ_ZP,
			pcinc8_pkg::ASL_ZP, pcinc8_pkg::ROL_ZP, pcinc8_pkg::LSR_ZP,
			pcinc8_pkg::ROR_ZP, pcinc8_pkg::INC_ZP, pcinc8_pkg::DEC_ZP,
			pcinc8_pkg::ADC_ZPX, pcinc8_pkg::SBC_ZPX, pcinc8_pkg::CMP_ZPX,
			pcinc8_pkg::AND_ZPX, pcinc8_pkg::ORA_ZPX, pcinc8_pkg::EOR_ZPX,
			pcinc8_pkg::LDA_ZPX, pcinc8_pkg::STA_ZPX, pcinc8_pkg::LDY_ZPX,
			pcinc8_pkg::STY_ZPX, pcinc8_pkg::BIT_ZPX, pcinc8_pkg::STZ_ZPX,
			pcinc8_pkg::ASL_ZPX, pcinc8_pkg::ROL_ZPX, pcinc8_pkg::LSR_ZPX,
			pcinc8_pkg::ROR_ZPX, pcinc8_pkg::INC_ZPX, pcinc8_pkg::DEC_ZPX,
			pcinc8_pkg::LDX_ZPY, pcinc8_pkg::STX_ZPY,
			pcinc8_pkg::ADC_I, pcinc8_pkg::SBC_I, pcinc8_pkg::AND_I, pcinc8_pkg::ORA_I,
			pcinc8_pkg::EOR_I, pcinc8_pkg::CMP_I, pcinc8_pkg::LDA_I, pcinc8_pkg::STA_I,
			pcinc8_pkg::ADC_IL, pcinc8_pkg::SBC_IL, pcinc8_pkg::AND_IL,
			pcinc8_pkg::ORA_IL, pcinc8_pkg::EOR_IL, pcinc8_pkg::CMP_IL,
			pcinc8_pkg::LDA_IL, pcinc8_pkg::STA_IL,
			pcinc8_pkg::ADC_IX, pcinc8_pkg::SBC_IX, pcinc8_pkg::CMP_IX,
			pcinc8_pkg::AND_IX, pcinc8_pkg::ORA_IX, pcinc8_pkg::EOR_IX,
			pcinc8_pkg::LDA_IX, pcinc8_pkg::STA_IX,
			pcinc8_pkg::ADC_IY, pcinc8_pkg::SBC_IY, pcinc8_pkg::CMP_IY,
			pcinc8_pkg::AND_IY, pcinc8_pkg::ORA_IY, pcinc8_pkg::EOR_IY,
			pcinc8_pkg::LDA_IY, pcinc8_pkg::STA_IY,
			pcinc8_pkg::ADC_IYL, pcinc8_pkg::SBC_IYL, pcinc8_pkg::CMP_IYL,
			pcinc8_pkg::AND_IYL, pcinc8_pkg::ORA_IYL, pcinc8_pkg::EOR_IYL,
			pcinc8_pkg::LDA_IYL, pcinc8_pkg::STA_IYL,
			pcinc8_pkg::ADC_DSP, pcinc8_pkg::SBC_DSP, pcinc8_pkg::CMP_DSP,
			pcinc8_pkg::AND_DSP, pcinc8_pkg::ORA_DSP, pcinc8_pkg::EOR_DSP,
			pcinc8_pkg::LDA_DSP, pcinc8_pkg::STA_DSP,
			pcinc8_pkg::ADC_DSPIY, pcinc8_pkg::SBC_DSPIY, pcinc8_pkg::CMP_DSPIY,
			pcinc8_pkg::AND_DSPIY, pcinc8_pkg::ORA_DSPIY, pcinc8_pkg::EOR_DSPIY,
			pcinc8_pkg::LDA_DSPIY, pcinc8_pkg::STA_DSPIY:
				inc = 4'd2;

			// ====================================================
			// two operand bytes
			// ====================================================
			pcinc8_pkg::BRL, pcinc8_pkg::PEA, pcinc8_pkg::PER, pcinc8_pkg::MVN,
			pcinc8_pkg::MVP,
			pcinc8_pkg::TRB_ABS, pcinc8_pkg::TSB_ABS, pcinc8_pkg::ADC_ABS,
			pcinc8_pkg::SBC_ABS, pcinc8_pkg::CMP_ABS, pcinc8_pkg::AND_ABS,
			pcinc8_pkg::ORA_ABS, pcinc8_pkg::EOR_ABS, pcinc8_pkg::LDA_ABS,
			pcinc8_pkg::STA_ABS, pcinc8_pkg::LDX_ABS, pcinc8_pkg::LDY_ABS,
			pcinc8_pkg::STX_ABS, pcinc8_pkg::STY_ABS, pcinc8_pkg::CPX_ABS,
			pcinc8_pkg::CPY_ABS, pcinc8_pkg::BIT_ABS, pcinc8_pkg::STZ_ABS,
			pcinc8_pkg::ASL_ABS, pcinc8_pkg::ROL_ABS, pcinc8_pkg::LSR_ABS,
			pcinc8_pkg::ROR_ABS, pcinc8_pkg::INC_ABS, pcinc8_pkg::DEC_ABS,
			pcinc8_pkg::ADC_ABSX, pcinc8_pkg::SBC_ABSX, pcinc8_pkg::CMP_ABSX,
			pcinc8_pkg::AND_ABSX, pcinc8_pkg::ORA_ABSX, pcinc8_pkg::EOR_ABSX,
			pcinc8_pkg::LDA_ABSX, pcinc8_pkg::STA_ABSX, pcinc8_pkg::LDY_ABSX,
			pcinc8_pkg::BIT_ABSX, pcinc8_pkg::STZ_ABSX, pcinc8_pkg::ASL_ABSX,
			pcinc8_pkg::ROL_ABSX, pcinc8_pkg::LSR_ABSX, pcinc8_pkg::ROR_ABSX,
			pcinc8_pkg::INC_ABSX, pcinc8_pkg::DEC_ABSX, pcinc8_pkg::LDX_ABSY,
			pcinc8_pkg::ADC_ABSY, pcinc8_pkg::SBC_ABSY, pcinc8_pkg::CMP_ABSY,
			pcinc8_pkg::AND_ABSY, pcinc8_pkg::ORA_ABSY, pcinc8_pkg::EOR_ABSY,
			pcinc8_pkg::LDA_ABSY, pcinc8_pkg::STA_ABSY:
				inc = 4'd3;

			// long addressing carries a bank byte as well
			pcinc8_pkg::ADC_AL, pcinc8_pkg::SBC_AL, pcinc8_pkg::CMP_AL,
			pcinc8_pkg::AND_AL, pcinc8_pkg::ORA_AL, pcinc8_pkg::EOR_AL,
			pcinc8_pkg::LDA_AL, pcinc8_pkg::STA_AL,
			pcinc8_pkg::ADC_ALX, pcinc8_pkg::SBC_ALX, pcinc8_pkg::CMP_ALX,
			pcinc8_pkg::AND_ALX, pcinc8_pkg::ORA_ALX, pcinc8_pkg::EOR_ALX,
			pcinc8_pkg::LDA_ALX, pcinc8_pkg::STA_ALX:
				inc = 4'd4;

			// jumps, calls, returns and interrupts stop the walker
			// until the core reloads the pc
			pcinc8_pkg::BRK, pcinc8_pkg::COP, pcinc8_pkg::JMP, pcinc8_pkg::JML,
			pcinc8_pkg::JMP_IND, pcinc8_pkg::JMP_INDX, pcinc8_pkg::JML_IND,
			pcinc8_pkg::JSR, pcinc8_pkg::JSR_INDX, pcinc8_pkg::JSL,
			pcinc8_pkg::RTS, pcinc8_pkg::RTL, pcinc8_pkg::RTI:
				inc = 4'd0;

			default:
				inc = 4'd0;
			endcase
		end
	end

endmodule

/* mode_flags.sv */
// processor mode tracker for the length decoder
// follows E, M, X and C through REP, SEP, CLC, SEC and XCE

`timescale 1ns/1ps

module mode_flags (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       issue,
	input  logic [7:0] opcode,
	input  logic [7:0] imm,
	output logic       m16,
	output logic       xb16
);

	logic e_flag;
	logic m_flag;
	logic x_flag;
	logic c_flag;
	logic e_next;
	logic m_next;
	logic x_next;
	logic c_next;

	always_comb begin
		e_next = e_flag;
		m_next = m_flag;
		x_next = x_flag;
		c_next = c_flag;
		// only an issued instruction may change the mode
		if (issue) begin
			case (opcode)
			pcinc8_pkg::REP: begin
				if (imm[pcinc8_pkg::FLAG_C]) c_next = 1'b0;
				if (imm[pcinc8_pkg::FLAG_X]) x_next = 1'b0;
				if (imm[pcinc8_pkg::FLAG_M]) m_next = 1'b0;
			end
			pcinc8_pkg::SEP: begin
				if (imm[pcinc8_pkg::FLAG_C]) c_next = 1'b1;
				if (imm[pcinc8_pkg::FLAG_X]) x_next = 1'b1;
				if (imm[pcinc8_pkg::FLAG_M]) m_next = 1'b1;
			end
			pcinc8_pkg::CLC: c_next = 1'b0;
			pcinc8_pkg::SEC: c_next = 1'b1;
			// carry and emulation trade places
			pcinc8_pkg::XCE: begin
				c_next = e_flag;
				e_next = c_flag;
			end
			default: ;
			endcase
		end
		// emulation mode pins both register widths to eight bits
		if (e_next) begin
			m_next = 1'b1;
			x_next = 1'b1;
		end
	end

	// out of reset the core is in emulation mode with carry clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_flag <= 1'b1;
			m_flag <= 1'b1;
			x_flag <= 1'b1;
			c_flag <= 1'b0;
		end else begin
			e_flag <= e_next;
			m_flag <= m_next;
			x_flag <= x_next;
			c_flag <= c_next;
		end
	end

	assign m16  = ~m_flag;
	assign xb16 = ~x_flag;

endmodule

/* fetch_sequencer.sv */
// fetch sequencer of the instruction walker
// holds the pc, issues one decoded instruction per cycle, stops on a
// zero length opcode and waits there for an outside pc load

`timescale 1ns/1ps

module fetch_sequencer #(
	parameter int PC_W = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  pcinc8_pkg::fetch_win_t       fetch_data,
	input  logic [pcinc8_pkg::INC_W-1:0] inc,
	input  logic                         hold,
	input  logic                         pc_load,
	input  logic [PC_W-1:0]              pc_load_addr,
	output logic [PC_W-1:0]              pc,
	output logic [7:0]                   opcode,
	output logic [7:0]                   imm,
	output logic                         issue,
	output logic                         inst_valid,
	output logic [7:0]                   inst_opcode,
	output logic [23:0]                  inst_operand,
	output logic [pcinc8_pkg::INC_W-1:0] inst_len,
	output logic                         halted
);

	// run is the cycle in which the decoder result is acted upon
	logic run;
	// a zero length while running means a flow change was reached
	logic stop;

	// ============================================================
	// window split
	// ============================================================

	// the opcode comes from the instruction view of the window
	assign opcode = fetch_data.inst.opcode;
	// the REP and SEP mask is the first byte after the opcode
	assign imm    = fetch_data.bytes[1];

	// ============================================================
	// issue decision
	// ============================================================

	// the suppress check itself lives in the decoder, hold only tells
	// a stall apart from a stop
	assign run   = !hold && !halted && !pc_load;
	assign issue = run && (inc != '0);
	assign stop  = run && (inc == '0);

	// ============================================================
	// pc, halt and valid
	// ============================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc         <= '0;
			halted     <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= issue;
			// a load beats an issue and a stop in the same cycle
			if (pc_load) begin
				pc     <= pc_load_addr;
				halted <= 1'b0;
			end else if (issue) begin
				pc <= pc + PC_W'(inc);
			end else if (stop) begin
				halted <= 1'b1;
			end
		end
	end

	// issued instruction, qualified by inst_valid
	always_ff @(posedge clk) begin
		if (issue) begin
			inst_opcode  <= fetch_data.inst.opcode;
			inst_operand <= fetch_data.inst.operand;
			inst_len     <= inc;
		end
	end

endmodule

/* inst_fetch_top.sv */
// top level of the 65816 instruction walker
// joins the length decoder, the mode tracker and the fetch sequencer

`timescale 1ns/1ps

module inst_fetch_top #(
	parameter int PC_W = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  pcinc8_pkg::fetch_win_t       fetch_data,
	input  logic [3:0]                   suppress_pcinc,
	input  logic                         pc_load,
	input  logic [PC_W-1:0]              pc_load_addr,
	output logic [PC_W-1:0]              pc,
	output logic                         inst_valid,
	output logic [7:0]                   inst_opcode,
	output logic [23:0]                  inst_operand,
	output logic [pcinc8_pkg::INC_W-1:0] inst_len,
	output logic                         halted,
	output logic                         m16,
	output logic                         xb16
);

	logic [7:0]                   opcode;
	logic [7:0]                   imm;
	logic [pcinc8_pkg::INC_W-1:0] inc;
	logic                         hold;
	logic                         issue;

	// length of the opcode at pc under the current widths
	pcinc8 u_pcinc8 (
		.opcode         (opcode),
		.suppress_pcinc (suppress_pcinc),
		.m16            (m16),
		.xb16           (xb16),
		.inc            (inc),
		.hold           (hold)
	);

	// widths update on the issuing edge so the next opcode sees them
	mode_flags u_mode_flags (
		.clk    (clk),
		.rst_n  (rst_n),
		.issue  (issue),
		.opcode (opcode),
		.imm    (imm),
		.m16    (m16),
		.xb16   (xb16)
	);

	fetch_sequencer #(
		.PC_W (PC_W)
	) u_fetch_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_data   (fetch_data),
		.inc          (inc),
		.hold         (hold),
		.pc_load      (pc_load),
		.pc_load_addr (pc_load_addr),
		.pc           (pc),
		.opcode       (opcode),
		.imm          (imm),
		.issue        (issue),
		.inst_valid   (inst_valid),
		.inst_opcode  (inst_opcode),
		.inst_operand (inst_operand),
		.inst_len     (inst_len),
		.halted       (halted)
	);

endmodule

/* tb_inst_model.svh */
// reference model of the instruction walker
// random source, length rules by addressing mode column, mode flag tracking

`ifndef TB_INST_MODEL_SVH
`define TB_INST_MODEL_SVH

// model state, updated once per clock from the monitor
logic [15:0] m_pc;
logic        m_e;
logic        m_m;
logic        m_x;
logic        m_c;
logic        m_halted;
logic        m_valid;
logic [7:0]  m_op;
logic [23:0] m_operand;
logic [3:0]  m_len;

// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	lfsr_step = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// length from the low nibble column of the 65816 map, then the odd ones out
function automatic logic [3:0] expected_length(input logic [7:0] op, input logic m16,
		input logic xb16);
	logic [3:0] hi;
	logic [3:0] len;
	hi = op[7:4];
	case (op[3:0])
	4'h1, 4'h3, 4'h5, 4'h6, 4'h7: len = 4'd2;
	4'h8, 4'hA: len = 4'd1;
	// rtl is the only flow change in this column
	4'hB: len = (op == 8'h6B) ? 4'd0 : 4'd1;
	4'hD, 4'hE: len = 4'd3;
	4'hF: len = 4'd4;
	// odd rows are abs,y and even rows are accumulator immediates
	4'h9: len = hi[0] ? 4'd3 : (m16 ? 4'd3 : 4'd2);
	4'h0: begin
		// branches and bra, index immediates, else brk jsr rti rts
		if (hi[0] || hi == 4'h8)
			len = 4'd2;
		else if (hi >= 4'hA)
			len = xb16 ? 4'd3 : 4'd2;
		else
			len = 4'd0;
	end
	4'h2: begin
		if (hi[0])
			len = 4'd2;
		else if (hi == 4'h0 || hi == 4'h2)
			len = 4'd0;
		else if (hi == 4'h4)
			len = 4'd1;
		else if (hi == 4'h6 || hi == 4'h8)
			len = 4'd3;
		else if (hi == 4'hA)
			len = xb16 ? 4'd3 : 4'd2;
		else
			len = 4'd2;
	end
	// block moves and pea take two operand bytes
	4'h4: len = (op == 8'h44 || op == 8'h54 || op == 8'hF4) ? 4'd3 : 4'd2;
	default: begin
		// column c, absolute unless it is a jump
		if (op == 8'h4C || op == 8'h5C || op == 8'h6C || op == 8'h7C ||
				op == 8'hDC || op == 8'hFC)
			len = 4'd0;
		else
			len = 4'd3;
	end
	endcase
	expected_length = len;
endfunction

task automatic model_reset();
	m_pc = '0;
	m_e = 1'b1;
	m_m = 1'b1;
	m_x = 1'b1;
	m_c = 1'b0;
	m_halted = 1'b0;
	m_valid = 1'b0;
endtask

// rep, sep, clc, sec and xce, with emulation forcing eight bit widths
task automatic apply_flags(input logic [7:0] op, input logic [7:0] mask);
	logic old_e;
	old_e = m_e;
	case (op)
	8'hC2: begin
		if (mask[pcinc8_pkg::FLAG_C]) m_c = 1'b0;
		if (mask[pcinc8_pkg::FLAG_X]) m_x = 1'b0;
		if (mask[pcinc8_pkg::FLAG_M]) m_m = 1'b0;
	end
	8'hE2: begin
		if (mask[pcinc8_pkg::FLAG_C]) m_c = 1'b1;
		if (mask[pcinc8_pkg::FLAG_X]) m_x = 1'b1;
		if (mask[pcinc8_pkg::FLAG_M]) m_m = 1'b1;
	end
	8'h18: m_c = 1'b0;
	8'h38: m_c = 1'b1;
	8'hFB: begin
		m_e = m_c;
		m_c = old_e;
	end
	default: ;
	endcase
	if (m_e) begin
		m_m = 1'b1;
		m_x = 1'b1;
	end
endtask

// one clock of the walker, load first, then issue or stop
task automatic model_step(input logic load, input logic [15:0] load_addr,
		input logic [3:0] supp);
	logic [7:0] op;
	logic [3:0] len;
	logic       run;
	op = mem[m_pc];
	len = expected_length(op, !m_m, !m_x);
	run = (supp == pcinc8_pkg::SUPPRESS_NONE) && !m_halted && !load;
	m_valid = run && (len != 4'd0);
	if (m_valid) begin
		m_op = op;
		m_operand = {mem[m_pc + 16'd3], mem[m_pc + 16'd2], mem[m_pc + 16'd1]};
		m_len = len;
		apply_flags(op, mem[m_pc + 16'd1]);
		m_pc = m_pc + {12'd0, len};
	end
	if (load) begin
		m_pc = load_addr;
		m_halted = 1'b0;
	end else if (run && len == 4'd0) begin
		m_halted = 1'b1;
	end
endtask

`endif

/* tb_inst_fetch.sv */
// testbench for the 65816 instruction walker
// random program memory with a reference model that predicts every issue,
// plus directed mode tracking and load priority sequences

`timescale 1ns/1ps

module tb_inst_fetch;

	// ============================================================
	// run length and directed programs
	// ============================================================

	localparam int PC_W            = 16;
	localparam int RESET_CYCLES    = 3;
	localparam int RAND_CYCLES     = 3000;
	localparam int SUPP_CYCLES     = 2000;
	localparam int DIRECTED_CYCLES = 80;
	localparam int PLAN_CYCLES     = RESET_CYCLES + RAND_CYCLES + SUPP_CYCLES + DIRECTED_CYCLES;
	localparam int TIMEOUT_CYCLES  = 2 * PLAN_CYCLES;

	// clc xce rep #30 lda #16 ldx #16 sep #20 lda #8 sec xce lda #8 ldx #8 brk
	localparam logic [7:0] MODE_PROG [0:20] = '{
		8'h18, 8'hFB, 8'hC2, 8'h30, 8'hA9, 8'h34, 8'h12, 8'hA2, 8'h78, 8'h56, 8'hE2,
		8'h20, 8'hA9, 8'h55, 8'h38, 8'hFB, 8'hA9, 8'h66, 8'hA2, 8'h77, 8'h00};
	// lengths the mode rules give for each of the eleven issues above
	localparam logic [3:0] MODE_LEN [0:10] = '{
		4'd1, 4'd1, 4'd2, 4'd3, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd2, 4'd2};

	logic            clk = 1'b0;
	logic            rst_n;
	logic [31:0]     fetch_word;
	logic [3:0]      suppress_pcinc;
	logic            pc_load;
	logic [PC_W-1:0] pc_load_addr;
	logic [PC_W-1:0] pc;
	logic            inst_valid;
	logic [7:0]      inst_opcode;
	logic [23:0]     inst_operand;
	logic [3:0]      inst_len;
	logic            halted;
	logic            m16;
	logic            xb16;

	logic [7:0]  mem [0:65535];
	logic [31:0] lfsr_state;
	int          errors = 0;
	int          issued = 0;
	int          reloads = 0;
	int          cycle_count = 0;
	logic [3:0]  seen_len [$];

	`include "tb_inst_model.svh"

	inst_fetch_top #(
		.PC_W (PC_W)
	) u_inst_fetch_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.fetch_data     (fetch_word),
		.suppress_pcinc (suppress_pcinc),
		.pc_load        (pc_load),
		.pc_load_addr   (pc_load_addr),
		.pc             (pc),
		.inst_valid     (inst_valid),
		.inst_opcode    (inst_opcode),
		.inst_operand   (inst_operand),
		.inst_len       (inst_len),
		.halted         (halted),
		.m16            (m16),
		.xb16           (xb16)
	);

	// program memory seen through the four byte window at pc
	assign fetch_word = {mem[pc + 16'd3], mem[pc + 16'd2], mem[pc + 16'd1], mem[pc]};

	always #2 clk = ~clk;

	// ============================================================
	// helpers
	// ============================================================

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at time %0t: %s got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// one lfsr step per bit taken, first bit ends up as the msb
	task automatic get_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// inputs change 1 ns after the edge and hold through the next one
	task automatic drive_cycle(input logic load, input logic [15:0] addr, input logic [3:0] supp);
		pc_load = load;
		pc_load_addr = addr;
		suppress_pcinc = supp;
		@(posedge clk);
		#1;
	endtask

	task automatic wait_halted();
		while (!halted)
			drive_cycle(1'b0, 16'h0000, pcinc8_pkg::SUPPRESS_NONE);
	endtask

	// ============================================================
	// monitor, compares the DUT with the model at mid cycle
	// ============================================================

	always @(negedge clk) begin
		if (!rst_n) begin
			model_reset();
		end else begin
			check_value("pc", 32'(pc), 32'(m_pc));
			check_value("halted", 32'(halted), 32'(m_halted));
			check_value("inst_valid", 32'(inst_valid), 32'(m_valid));
			check_value("m16", 32'(m16), 32'(!m_m));
			check_value("xb16", 32'(xb16), 32'(!m_x));
			if (inst_valid && m_valid) begin
				check_value("inst_opcode", 32'(inst_opcode), 32'(m_op));
				check_value("inst_operand", 32'(inst_operand), 32'(m_operand));
				check_value("inst_len", 32'(inst_len), 32'(m_len));
				issued++;
				seen_len.push_back(inst_len);
			end
			// inputs for the coming edge are stable by now
			model_step(pc_load, pc_load_addr, suppress_pcinc);
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ============================================================
	// stimulus
	// ============================================================

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		rst_n = 1'b0;
		suppress_pcinc = pcinc8_pkg::SUPPRESS_NONE;
		pc_load = 1'b0;
		pc_load_addr = '0;
		lfsr_state = 32'h6327;
		for (int i = 0; i < 65536; i++) begin
			get_bits(8, r);
			mem[16'(i)] = r[7:0];
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// reset state, before any edge out of reset
		check_value("pc after reset", 32'(pc), 32'd0);
		check_value("inst_valid after reset", 32'(inst_valid), 32'd0);
		check_value("halted after reset", 32'(halted), 32'd0);
		check_value("m16 after reset", 32'(m16), 32'd0);
		check_value("xb16 after reset", 32'(xb16), 32'd0);

		// random streams, reload on every halt and now and then while running
		for (int i = 0; i < RAND_CYCLES; i++) begin
			get_bits(4, r);
			if (halted || r[3:0] == 4'd0) begin
				if (halted)
					reloads++;
				get_bits(16, a);
				drive_cycle(1'b1, a[15:0], pcinc8_pkg::SUPPRESS_NONE);
			end else begin
				drive_cycle(1'b0, 16'h0000, pcinc8_pkg::SUPPRESS_NONE);
			end
		end
		check_value("halts followed by reload", 32'(reloads != 0), 32'd1);

		// random stalls, about one cycle in four
		for (int i = 0; i < SUPP_CYCLES; i++) begin
			get_bits(2, r);
			get_bits(16, a);
			if (halted)
				drive_cycle(1'b1, a[15:0], pcinc8_pkg::SUPPRESS_NONE);
			else if (r[1:0] == 2'd0)
				drive_cycle(1'b0, 16'h0000, (a[3:0] == 4'hF) ? 4'h0 : a[3:0]);
			else
				drive_cycle(1'b0, 16'h0000, pcinc8_pkg::SUPPRESS_NONE);
		end

		// mode tracking through clc, xce, rep, sep and sec
		for (int i = 0; i < 21; i++)
			mem[16'h8000 + 16'(i)] = MODE_PROG[5'(i)];
		drive_cycle(1'b1, 16'h8000, pcinc8_pkg::SUPPRESS_NONE);
		seen_len.delete();
		wait_halted();
		check_value("mode sequence issues", 32'(seen_len.size()), 32'd11);
		for (int i = 0; i < 11 && i < seen_len.size(); i++)
			check_value("mode sequence length", 32'(seen_len[i]), 32'(MODE_LEN[4'(i)]));

		// a load in an issuing cycle wins over the nop sled at the old pc
		for (int i = 0; i < 16; i++)
			mem[16'h4000 + 16'(i)] = 8'hEA;
		for (int i = 0; i < 4; i++)
			mem[16'h4100 + 16'(i)] = 8'hEA;
		mem[16'h4104] = 8'h00;
		drive_cycle(1'b1, 16'h4000, pcinc8_pkg::SUPPRESS_NONE);
		repeat (3) drive_cycle(1'b0, 16'h0000, pcinc8_pkg::SUPPRESS_NONE);
		check_value("running before load", 32'(halted), 32'd0);
		drive_cycle(1'b1, 16'h4100, pcinc8_pkg::SUPPRESS_NONE);
		check_value("inst_valid after load", 32'(inst_valid), 32'd0);
		check_value("pc after load", 32'(pc), 32'h4100);
		wait_halted();
		repeat (2) drive_cycle(1'b0, 16'h0000, pcinc8_pkg::SUPPRESS_NONE);

		$display("summary: %0d instructions checked, %0d errors", issued, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
pcinc8_pkg.sv
pcinc8.sv
mode_flags.sv
fetch_sequencer.sv
inst_fetch_top.sv
tb_inst_fetch.sv

/* Makefile */
# Verilator build and run for the 65816 instruction walker

VERILATOR ?= verilator
TOP       ?= tb_inst_fetch
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FILELIST  ?= verilog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(SIM_DIR)

# the log decides the result, the simulator status alone is not enough
run: build
	./$(SIM_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR) $(LOG)
